//--- logic/uart_defs.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART definitions
// FIFO depth, reset divisor, stop-bit setting and the register map
// shared by the UART, its echo controller and the testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

`define UART_FIFO_DEPTH 8

// Clocks per bit after reset
`define UART_DIV_RESET 16'd16

// 0 gives one stop bit, 1 gives two
`define UART_NSTOP 1'b1

`define UART_REG_TXDATA 3'd0
`define UART_REG_RXDATA 3'd1
`define UART_REG_TXCTRL 3'd2
`define UART_REG_RXCTRL 3'd3
`define UART_REG_IP     3'd5
`define UART_REG_DIV    3'd6

`endif

//--- logic/uart_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART package
// Data widths, Wishbone request and response structs and the
// echo controller state encoding
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package uart_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [2:0]  wb_addr_t;
  typedef logic [31:0] wb_data_t;
  typedef logic [3:0]  fifo_count_t;
  typedef logic [2:0]  watermark_t;
  typedef logic [15:0] baud_div_t;

  // Master to slave
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic     ack;
    wb_data_t dat;
  } wb_rsp_t;

  typedef enum logic [2:0] {
    idle,
    conf_rx,
    conf_tx,
    poll_ip,
    read_rx,
    write_tx
  } echo_state_t;

endpackage

//--- logic/uart_fifo.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART byte FIFO
// Circular buffer with a fill count, head entry always visible on rdata
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "uart_defs.svh"

module uart_fifo (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  push,
  input  logic                  pop,
  input  uart_pkg::byte_t       wdata,
  output uart_pkg::byte_t       rdata,
  output uart_pkg::fifo_count_t count,
  output logic                  empty,
  output logic                  full
);
  import uart_pkg::*;

  localparam int aw = $clog2(`UART_FIFO_DEPTH);

  byte_t         mem [`UART_FIFO_DEPTH];
  logic [aw-1:0] wr_ptr;
  logic [aw-1:0] rd_ptr;
  logic          do_push;
  logic          do_pop;

  assign empty   = (count == '0);
  assign full    = (count == fifo_count_t'(`UART_FIFO_DEPTH));
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign rdata   = mem[rd_ptr];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      // Simultaneous push and pop leaves the count alone
      if (do_push && !do_pop) count <= count + 1'b1;
      else if (!do_push && do_pop) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (do_push) mem[wr_ptr] <= wdata;
  end

endmodule

//--- logic/uart_tx.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART serializer
// Sends start bit, eight data bits LSB first and one or two stop bits,
// each bit held for div clocks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module uart_tx (
  input  logic                clock,
  input  logic                reset,
  input  uart_pkg::baud_div_t div,
  input  logic                nstop,
  input  logic                start,
  input  uart_pkg::byte_t     data,
  output logic                busy,
  output logic                txd
);
  import uart_pkg::*;

  baud_div_t   tick_cnt;
  logic [3:0]  bits_left;
  logic [10:0] shreg;
  logic        bit_done;
  logic        load;

  assign load     = start && !busy;
  assign bit_done = (tick_cnt == div - 16'd1);

  // Line idles high
  assign txd = busy ? shreg[0] : 1'b1;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      busy      <= 1'b0;
      tick_cnt  <= '0;
      bits_left <= '0;
    end else if (load) begin
      busy      <= 1'b1;
      tick_cnt  <= '0;
      bits_left <= nstop ? 4'd11 : 4'd10;
    end else if (busy) begin
      if (bit_done) begin
        tick_cnt  <= '0;
        bits_left <= bits_left - 1'b1;
        if (bits_left == 4'd1) busy <= 1'b0;
      end else begin
        tick_cnt <= tick_cnt + 1'b1;
      end
    end
  end

  // Stop bits come from the ones shifted in at the top
  always_ff @(posedge clock) begin
    if (load) shreg <= {2'b11, data, 1'b0};
    else if (busy && bit_done) shreg <= {1'b1, shreg[10:1]};
  end

endmodule

//--- logic/uart_rx.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART deserializer
// Two-flop input sync, falling edge start detect, start bit recheck at
// half a bit, mid-bit data sampling and stop bit check
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module uart_rx (
  input  logic                clock,
  input  logic                reset,
  input  uart_pkg::baud_div_t div,
  input  logic                enable,
  input  logic                rxd,
  output logic                valid,
  output uart_pkg::byte_t     data
);
  import uart_pkg::*;

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_t;

  rx_state_t  state;
  logic       rxd_meta;
  logic       rxd_sync;
  logic       rxd_prev;
  baud_div_t  tick_cnt;
  logic [2:0] bit_idx;
  byte_t      shreg;
  logic       full_bit;
  logic       half_bit;

  assign full_bit = (tick_cnt == div - 16'd1);
  assign half_bit = (tick_cnt == {1'b0, div[15:1]} - 16'd1);
  assign data     = shreg;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state    <= rx_idle;
      tick_cnt <= '0;
      bit_idx  <= '0;
      valid    <= 1'b0;
    end else begin
      valid <= 1'b0;
      case (state)
        rx_idle: begin
          if (enable && rxd_prev && !rxd_sync) begin
            state    <= rx_start;
            tick_cnt <= '0;
          end
        end
        rx_start: begin
          if (half_bit) begin
            tick_cnt <= '0;
            bit_idx  <= '0;
            // Glitch shorter than half a bit goes back to idle
            state    <= rxd_sync ? rx_idle : rx_data;
          end else begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        rx_data: begin
          if (full_bit) begin
            tick_cnt <= '0;
            bit_idx  <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= rx_stop;
          end else begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        rx_stop: begin
          if (full_bit) begin
            tick_cnt <= '0;
            valid    <= rxd_sync;
            state    <= rx_idle;
          end else begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == rx_data && full_bit) shreg <= {rxd_sync, shreg[7:1]};
  end

endmodule

//--- logic/uart.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone UART
// Classic slave with divisor, control and pending registers, transmit
// and receive FIFOs, serializer and deserializer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "uart_defs.svh"

module uart (
  input  logic              clock,
  input  logic              reset,
  input  uart_pkg::wb_req_t wb_req,
  output uart_pkg::wb_rsp_t wb_rsp,
  input  logic              rxd,
  output logic              txd
);
  import uart_pkg::*;

  baud_div_t   div;
  logic        txen;
  logic        nstop;
  watermark_t  txcnt;
  logic        rxen;
  watermark_t  rxcnt;
  logic        txwm;
  logic        rxwm;
  logic        req_valid;
  logic        tx_stall;
  logic        do_access;
  logic        do_write;
  logic        ack_q;
  wb_data_t    rdat;
  wb_data_t    rdat_q;
  logic        tx_push;
  logic        tx_pop;
  logic        tx_empty;
  logic        tx_full;
  logic        tx_busy;
  byte_t       tx_byte;
  fifo_count_t tx_count;
  logic        rx_valid;
  logic        rx_push;
  logic        rx_pop;
  logic        rx_empty;
  logic        rx_full;
  byte_t       rx_in;
  byte_t       rx_byte;
  fifo_count_t rx_count;

  // A txdata write to a full FIFO holds off ack until a slot frees
  assign req_valid = wb_req.cyc && wb_req.stb && !ack_q;
  assign tx_stall  = wb_req.we && (wb_req.adr == `UART_REG_TXDATA) && tx_full;
  assign do_access = req_valid && !tx_stall;
  assign do_write  = do_access && wb_req.we;

  assign tx_push = do_write && (wb_req.adr == `UART_REG_TXDATA);
  assign rx_pop  = do_access && !wb_req.we && (wb_req.adr == `UART_REG_RXDATA);
  assign tx_pop  = txen && !tx_empty && !tx_busy;
  assign rx_push = rx_valid && !rx_full;

  assign txwm = (tx_count < {1'b0, txcnt});
  assign rxwm = (rx_count > {1'b0, rxcnt});

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = rdat_q;

  always_comb begin
    rdat = '0;
    case (wb_req.adr)
      `UART_REG_TXDATA: rdat[31] = tx_full;
      `UART_REG_RXDATA: begin
        rdat[31]  = rx_empty;
        rdat[7:0] = rx_byte;
      end
      `UART_REG_TXCTRL: begin
        rdat[0]     = txen;
        rdat[1]     = nstop;
        rdat[18:16] = txcnt;
      end
      `UART_REG_RXCTRL: begin
        rdat[0]     = rxen;
        rdat[18:16] = rxcnt;
      end
      `UART_REG_IP:  rdat[1:0] = {rxwm, txwm};
      `UART_REG_DIV: rdat[15:0] = div;
      default: rdat = '0;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      ack_q <= 1'b0;
      div   <= `UART_DIV_RESET;
      txen  <= 1'b0;
      nstop <= 1'b0;
      txcnt <= '0;
      rxen  <= 1'b0;
      rxcnt <= '0;
    end else begin
      ack_q <= do_access;
      if (do_write) begin
        case (wb_req.adr)
          `UART_REG_TXCTRL: begin
            txen  <= wb_req.dat[0];
            nstop <= wb_req.dat[1];
            txcnt <= wb_req.dat[18:16];
          end
          `UART_REG_RXCTRL: begin
            rxen  <= wb_req.dat[0];
            rxcnt <= wb_req.dat[18:16];
          end
          `UART_REG_DIV: div <= wb_req.dat[15:0];
          default: ;
        endcase
      end
    end
  end

  // Read data captured before the pop takes effect
  always_ff @(posedge clock) begin
    if (do_access) rdat_q <= rdat;
  end

  uart_fifo u_tx_fifo (
    .clock(clock),
    .reset(reset),
    .push (tx_push),
    .pop  (tx_pop),
    .wdata(wb_req.dat[7:0]),
    .rdata(tx_byte),
    .count(tx_count),
    .empty(tx_empty),
    .full (tx_full)
  );

  uart_fifo u_rx_fifo (
    .clock(clock),
    .reset(reset),
    .push (rx_push),
    .pop  (rx_pop),
    .wdata(rx_in),
    .rdata(rx_byte),
    .count(rx_count),
    .empty(rx_empty),
    .full (rx_full)
  );

  uart_tx u_tx (
    .clock(clock),
    .reset(reset),
    .div  (div),
    .nstop(nstop),
    .start(tx_pop),
    .data (tx_byte),
    .busy (tx_busy),
    .txd  (txd)
  );

  uart_rx u_rx (
    .clock (clock),
    .reset (reset),
    .div   (div),
    .enable(rxen),
    .rxd   (rxd),
    .valid (rx_valid),
    .data  (rx_in)
  );

endmodule

//--- logic/uart_echo_ctrl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART echo controller
// Wishbone classic master that enables the UART, polls the receive
// watermark and writes every received byte back to the transmitter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "uart_defs.svh"

module uart_echo_ctrl (
  input  logic              clock,
  input  logic              reset,
  output uart_pkg::wb_req_t wb_req,
  input  uart_pkg::wb_rsp_t wb_rsp
);
  import uart_pkg::*;

  // rxen with rxcnt 0, so one byte raises rxwm
  localparam wb_data_t rxctrl_conf = 32'h0000_0001;
  // txen, stop bits and txcnt 1
  localparam wb_data_t txctrl_conf = {13'd0, 3'd1, 14'd0, `UART_NSTOP, 1'b1};

  echo_state_t state;
  wb_req_t     req;
  byte_t       echo_byte;
  logic        done;

  function automatic wb_req_t bus_access(logic we, wb_addr_t adr, wb_data_t dat);
    return '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
  endfunction

  assign wb_req = req;
  assign done   = req.stb && wb_rsp.ack;

  // Request held until ack, then one idle cycle before the next one
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= idle;
      req   <= '0;
    end else if (req.stb) begin
      if (done) begin
        req <= '0;
        case (state)
          conf_rx: state <= conf_tx;
          conf_tx: state <= poll_ip;
          // Bit 1 of ip is rxwm
          poll_ip: if (wb_rsp.dat[1]) state <= read_rx;
          read_rx: state <= wb_rsp.dat[31] ? poll_ip : write_tx;
          write_tx: state <= poll_ip;
          default: state <= idle;
        endcase
      end
    end else begin
      case (state)
        idle:     state <= conf_rx;
        conf_rx:  req <= bus_access(1'b1, `UART_REG_RXCTRL, rxctrl_conf);
        conf_tx:  req <= bus_access(1'b1, `UART_REG_TXCTRL, txctrl_conf);
        poll_ip:  req <= bus_access(1'b0, `UART_REG_IP, '0);
        read_rx:  req <= bus_access(1'b0, `UART_REG_RXDATA, '0);
        write_tx: req <= bus_access(1'b1, `UART_REG_TXDATA, {24'd0, echo_byte});
        default:  state <= idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (done && state == read_rx) echo_byte <= wb_rsp.dat[7:0];
  end

endmodule

//--- logic/uart_echo_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART echo top level
// Echo controller driving the UART over Wishbone
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module uart_echo_top (
  input  logic clock,
  input  logic reset,
  input  logic rxd,
  output logic txd
);
  import uart_pkg::*;

  wb_req_t wb_req;
  wb_rsp_t wb_rsp;

  uart_echo_ctrl u_ctrl (
    .clock (clock),
    .reset (reset),
    .wb_req(wb_req),
    .wb_rsp(wb_rsp)
  );

  uart u_uart (
    .clock (clock),
    .reset (reset),
    .wb_req(wb_req),
    .wb_rsp(wb_rsp),
    .rxd   (rxd),
    .txd   (txd)
  );

endmodule

//--- verif/uart_echo_props.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART bus and line properties
// Wishbone handshake rules and idle line level, bound into the UART
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module uart_echo_props (
  input logic              clock,
  input logic              reset,
  input uart_pkg::wb_req_t wb_req,
  input uart_pkg::wb_rsp_t wb_rsp,
  input logic              tx_busy,
  input logic              txd
);

  stb_needs_cyc: assert property (
    @(posedge clock) disable iff (reset) wb_req.stb |-> wb_req.cyc
  ) else $error("Wishbone stb raised without cyc");

  // One ack per access
  ack_single_cycle: assert property (
    @(posedge clock) disable iff (reset) wb_rsp.ack |=> !wb_rsp.ack
  ) else $error("Wishbone ack held for two cycles");

  idle_line_high: assert property (
    @(posedge clock) disable iff (reset) !tx_busy |-> txd
  ) else $error("txd low while the serializer is idle");

endmodule

bind uart uart_echo_props u_props (
  .clock  (clock),
  .reset  (reset),
  .wb_req (wb_req),
  .wb_rsp (wb_rsp),
  .tx_busy(tx_busy),
  .txd    (txd)
);

//--- verif/uart_echo_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART echo testbench
// Sends serial frames on rxd, watches txd for the echoed frames and
// compares each one with the expected line pattern
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "uart_defs.svh"

module uart_echo_tb;
  import uart_pkg::*;

  localparam int bit_clocks   = int'(`UART_DIV_RESET);
  localparam int frame_len    = (`UART_NSTOP == 1'b1) ? 11 : 10;
  localparam int clock_ns     = 8;
  localparam int total_frames = 81;
  localparam int watchdog_ns  =
    (3 * total_frames * frame_len + 60) * bit_clocks * clock_ns;
  localparam logic [31:0] rand_seed = 32'hdbda_a109;

  logic  clock;
  logic  reset;
  logic  rxd;
  logic  txd;
  byte_t exp_q [$];
  int    mismatch_count = 0;
  int    problem_count = 0;
  int    frames_seen = 0;
  int    reset_count = 0;
  logic  frame_active = 1'b0;

  uart_echo_top dut0 (
    .clock(clock),
    .reset(reset),
    .rxd  (rxd),
    .txd  (txd)
  );

  initial begin
    clock = 1'b0;
    forever #(clock_ns / 2) clock = ~clock;
  end

  // Line bits in time order: start, data LSB first, stop bits
  function automatic logic [10:0] frame_bits(input byte_t b);
    logic [10:0] bits;
    bits = '1;
    bits[0] = 1'b0;
    for (int i = 0; i < 8; i++) bits[i + 1] = b[i];
    return bits;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("FAILED %0t ns: %s", $time, msg);
    mismatch_count++;
  endtask

  task automatic report_problem(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    problem_count++;
  endtask

  // Ends 1 ns after a rising edge
  task automatic wait_clocks(input int n);
    if (n > 0) begin
      repeat (n) @(posedge clock);
      #1;
    end
  endtask

  task automatic send_byte(input byte_t b, input logic stop_val);
    logic [10:0] bits;
    bits = frame_bits(b);
    bits[9] = stop_val;
    for (int i = 0; i < 10; i++) begin
      rxd = bits[i];
      wait_clocks(bit_clocks);
    end
    rxd = 1'b1;
  endtask

  task automatic expect_byte(input byte_t b);
    exp_q.push_back(b);
    send_byte(b, 1'b1);
  endtask

  task automatic wait_drain();
    int limit;
    int waited;
    limit = (exp_q.size() + 2) * frame_len * bit_clocks * 2;
    waited = 0;
    while (exp_q.size() != 0 && waited < limit) begin
      wait_clocks(1);
      waited++;
    end
    if (exp_q.size() != 0) begin
      report_problem($sformatf("%0d echoed bytes never appeared on txd", exp_q.size()));
    end
    exp_q.delete();
  endtask

  initial begin : line_monitor
    logic [10:0] got;
    logic [10:0] want;
    byte_t       exp_byte;
    int          resets_at_start;
    forever begin
      @(negedge txd);
      resets_at_start = reset_count;
      frame_active = 1'b1;
      got = '1;
      // First sample in the middle of the start bit
      repeat (bit_clocks / 2) @(negedge clock);
      for (int i = 0; i < frame_len; i++) begin
        got[i] = txd;
        if (i < frame_len - 1) repeat (bit_clocks) @(negedge clock);
      end
      frame_active = 1'b0;
      // Frames cut short by a reset are not compared
      if (resets_at_start == reset_count) begin
        frames_seen++;
        if (exp_q.size() == 0) begin
          report_problem($sformatf("unexpected frame %b seen on txd", got));
        end else begin
          exp_byte = exp_q.pop_front();
          want = frame_bits(exp_byte);
          if (got[frame_len-1:0] !== want[frame_len-1:0]) begin
            report_mismatch($sformatf("byte %h framed as %b, expected %b",
              exp_byte, got[frame_len-1:0], want[frame_len-1:0]));
          end
        end
      end
    end
  end

  initial begin : stimulus
    byte_t b;
    int    gap;
    int    seen;
    int    waited;
    void'($urandom(rand_seed));
    rxd = 1'b1;
    reset = 1'b1;
    wait_clocks(10);
    reset = 1'b0;

    // Quiet line after reset
    for (int i = 0; i < 20 * bit_clocks; i++) begin
      wait_clocks(1);
      if (txd !== 1'b1) report_mismatch($sformatf("txd is %b on an idle line", txd));
    end
    if (frames_seen != 0) report_problem("frame seen with no input");

    // Single byte, echoed once
    seen = frames_seen;
    expect_byte(8'ha5);
    wait_drain();
    wait_clocks(2 * frame_len * bit_clocks);
    if (frames_seen != seen + 1) begin
      report_problem($sformatf("one byte gave %0d frames", frames_seen - seen));
    end

    // Back to back, more than the FIFO depth
    for (int i = 0; i < 12; i++) expect_byte(byte_t'(8'h30 + i));
    wait_drain();

    for (int i = 0; i < 64; i++) begin
      b = byte_t'($urandom);
      gap = $urandom_range(3, 0);
      expect_byte(b);
      wait_clocks(gap * bit_clocks);
    end
    wait_drain();

    // Low stop bit, then a good frame
    send_byte(8'h5a, 1'b0);
    wait_clocks(bit_clocks);
    expect_byte(8'hc3);
    wait_drain();

    // Reset in the middle of an echoed frame
    expect_byte(8'h96);
    waited = 0;
    while (!frame_active && waited < 40 * bit_clocks) begin
      wait_clocks(1);
      waited++;
    end
    if (!frame_active) report_problem("echo before the mid-run reset never started");
    // Still inside the low start bit
    wait_clocks(bit_clocks / 2);
    reset = 1'b1;
    reset_count++;
    exp_q.delete();
    #1;
    if (txd !== 1'b1) report_mismatch($sformatf("txd is %b right after reset", txd));
    wait_clocks(10);
    reset = 1'b0;
    wait_clocks(bit_clocks);
    expect_byte(8'h3c);
    wait_drain();

    $display("Run complete: %0d frames, %0d mismatches, %0d other errors",
      frames_seen, mismatch_count, problem_count);
    if (mismatch_count == 0 && problem_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns before the tests finished", watchdog_ns);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- sources.f
+incdir+logic
logic/uart_pkg.sv
logic/uart_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart.sv
logic/uart_echo_ctrl.sv
logic/uart_echo_top.sv
verif/uart_echo_props.sv
verif/uart_echo_tb.sv

//--- Makefile
# Verilator build for the UART echo testbench

VERILATOR ?= verilator
FLAGS     ?= --timing --assert -Wno-fatal
TOP       ?= uart_echo_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
